// ==== chroni.f ====
chroni_pkg.sv
chroni_regs.sv
chroni_timing.sv
chroni_text_fetch.sv
chroni_line_buffer.sv
chroni_video_out.sv
chroni.sv
chroni_checker.sv
chroni_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module chroni_tb \
   -f chroni.f -o sim_chroni \
   && ./obj_dir/sim_chroni > sim.log 2>&1
grep -q "^TEST PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== chroni_tb.sv ====
module chroni_tb import chroni_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      vga_mode_e mode;
      int        h_total;
      int        v_total;
      int        hs_width;
      int        h_de_s;
      int        h_de_e;
      int        h_pf_s;
      int        h_pf_e;
      int        v_de_s;
      int        v_de_e;
      int        v_pf_s;
      int        v_pf_e;
      int        cols;
      bit        dbl;
   } mode_exp_t;

   typedef struct packed {
      logic [6:0] addr;
      logic [7:0] wdata;
      logic [7:0] rdata;
   } reg_step_t;

   // display and playfield ranges run from beam x and y of *_s + 1 up to *_e
   localparam mode_exp_t modes [3] = '{
      '{mode_640x480, 800, 525, 96, 144, 784, 144, 784, 35, 515, 35, 515, 40, 1'b1},
      '{mode_800x600, 1056, 628, 128, 216, 1016, 296, 936, 27, 627, 87, 567, 40, 1'b1},
      '{mode_1280x720, 1650, 750, 40, 260, 1540, 420, 1380, 25, 745, 25, 745, 120, 1'b0}
   };

   // high bytes of the bases keep 5 bits
   // unused addresses read zero
   localparam reg_step_t reg_steps [13] = '{
      '{7'd0, 8'he0, 8'he0}, '{7'd1, 8'h07, 8'h07},
      '{7'd2, 8'hff, 8'hff}, '{7'd3, 8'hff, 8'hff},
      '{7'd4, 8'h1f, 8'h1f}, '{7'd5, 8'h00, 8'h00},
      '{7'd6, 8'h00, 8'h00}, '{7'd7, 8'he0, 8'h00},
      '{7'd8, 8'h00, 8'h00}, '{7'd9, 8'hf0, 8'h10},
      '{7'd10, 8'ha5, 8'ha5}, '{7'd11, 8'h3c, 8'h00},
      '{7'd127, 8'hff, 8'h00}
   };

   localparam logic [12:0] text_base = 13'h0000;
   localparam logic [12:0] font_base = 13'h1000;
   localparam logic [15:0] border_c  = 16'h07e0;
   localparam logic [15:0] fg_c      = 16'hffff;
   localparam logic [15:0] bg_c      = 16'h001f;
   localparam logic [7:0]  page_c    = 8'ha5;

   logic        vga_clk;
   logic        reset_n;
   vga_mode_e   vga_mode_in;
   logic        vga_hs;
   logic        vga_vs;
   logic [4:0]  vga_r;
   logic [5:0]  vga_g;
   logic [4:0]  vga_b;
   logic [6:0]  cpu_addr;
   logic [7:0]  cpu_data_in;
   logic [7:0]  cpu_data_out;
   logic        cpu_we;
   logic        cpu_re;
   logic [12:0] addr_out;
   logic [7:0]  addr_out_page;
   logic [7:0]  data_in;
   logic        rd_req;
   logic        rd_ack;

   logic [7:0]  mem [8192];
   int          ack_wait;
   int          errors;
   int          pix_checks;
   bit          timed_out;
   bit          pix_check;
   int          cur;
   logic        prev_hs;
   logic        prev_vs;
   int          hx;
   int          vy;
   int          line_len;
   int          hs_width;
   int          frame_lines;
   int          frames;

   chroni dut0 (.*);

   always #5 vga_clk = ~vga_clk;

   // memory answers each request after 1 to 3 cycles with a one-cycle ack
   always @(negedge vga_clk) begin
      if (!reset_n || !rd_req) begin
         rd_ack   = 1'b0;
         ack_wait = 0;
      end else if (rd_ack) begin
         rd_ack = 1'b0;
      end else begin
         if (ack_wait == 0) begin
            ack_wait = 1 + int'($urandom % 3);
         end
         ack_wait--;
         if (ack_wait == 0) begin
            data_in = mem[addr_out];
            rd_ack  = 1'b1;
            assert (addr_out_page == page_c) else begin
               errors++;
               if (errors <= 10) begin
                  $display("Fail %0t: read page is %h, expected %h",
                           $time, addr_out_page, page_c);
               end
            end
         end
      end
   end

   function automatic bit glyph_bit(mode_exp_t m, int x, int y);
      int         px;
      int         line;
      int         col;
      int         row;
      logic [7:0] code;
      logic [7:0] glyph;
      px   = x - m.h_pf_s - 1;
      line = y - m.v_pf_s - 1;
      if (m.dbl) begin
         px   = px / 2;
         line = line / 2;
      end
      row   = line / 8;
      col   = px / 8;
      code  = mem[13'(int'(text_base) + row * m.cols + col)];
      glyph = code ^ 8'((line % 8) * 37);
      return glyph[7 - px % 8];
   endfunction

   // beam position rebuilt from the output sync edges
   // outputs lag the beam by one cycle
   always @(negedge vga_clk) begin : monitor
      mode_exp_t   m;
      bit          in_de;
      bit          in_pf;
      logic [15:0] got;
      logic [15:0] exp;
      if (prev_hs && !vga_hs) begin
         line_len = hx;
         hx       = 1;
         if (prev_vs && !vga_vs) begin
            frame_lines = vy;
            vy          = 1;
            frames++;
         end else begin
            vy++;
         end
      end else begin
         hx++;
      end
      if (!prev_hs && vga_hs) begin
         hs_width = hx - 1;
      end
      prev_hs = vga_hs;
      prev_vs = vga_vs;
      if (pix_check) begin
         m     = modes[cur];
         in_de = hx > m.h_de_s && hx <= m.h_de_e && vy > m.v_de_s && vy <= m.v_de_e;
         in_pf = hx > m.h_pf_s && hx <= m.h_pf_e && vy > m.v_pf_s && vy <= m.v_pf_e;
         got   = {vga_r, vga_g, vga_b};
         if (in_pf) begin
            exp = glyph_bit(m, hx, vy) ? fg_c : bg_c;
         end else if (in_de) begin
            exp = border_c;
         end else begin
            exp = 16'h0000;
         end
         pix_checks++;
         assert (got == exp) else begin
            errors++;
            if (errors <= 10) begin
               $display("Fail %0t: pixel x=%0d y=%0d is %h, expected %h",
                        $time, hx, vy, got, exp);
            end
         end
      end
   end

   task automatic wait_frames(input int n);
      int start;
      int cycles;
      start  = frames;
      cycles = 0;
      while (frames < start + n && cycles < n * 1500000) begin
         @(posedge vga_clk);
         cycles++;
      end
      if (frames < start + n) begin
         timed_out = 1'b1;
         $display("timeout while waiting for a frame start on vga_vs");
      end
   endtask

   task automatic reg_access(input reg_step_t s);
      @(negedge vga_clk);
      cpu_addr    = s.addr;
      cpu_data_in = s.wdata;
      cpu_we      = 1'b1;
      @(negedge vga_clk);
      cpu_we = 1'b0;
      cpu_re = 1'b1;
      @(negedge vga_clk);
      cpu_re = 1'b0;
      assert (cpu_data_out == s.rdata) else begin
         errors++;
         $display("Fail %0t: register %0d reads %h, expected %h",
                  $time, s.addr, cpu_data_out, s.rdata);
      end
   endtask

   initial begin
      void'($urandom(19560));
      vga_clk     = 1'b0;
      reset_n     = 1'b0;
      vga_mode_in = mode_640x480;
      cpu_addr    = 7'd0;
      cpu_data_in = 8'd0;
      cpu_we      = 1'b0;
      cpu_re      = 1'b0;
      data_in     = 8'd0;
      rd_ack      = 1'b0;
      errors      = 0;
      pix_checks  = 0;
      timed_out   = 1'b0;
      pix_check   = 1'b0;
      cur         = 0;
      prev_hs     = 1'b1;
      prev_vs     = 1'b1;
      hx          = 0;
      vy          = 0;
      frames      = 0;
      // font region holds char xor scan*37 and the rest holds random character codes
      for (int a = 0; a < 8192; a++) begin
         if (a >= int'(font_base) && a < int'(font_base) + 2048) begin
            mem[a] = 8'((a - int'(font_base)) >> 3) ^ 8'((a % 8) * 37);
         end else begin
            mem[a] = 8'($urandom);
         end
      end
      repeat (10) @(negedge vga_clk);
      assert (vga_hs && vga_vs && {vga_r, vga_g, vga_b} == 16'h0 && !rd_req) else begin
         errors++;
         $display("Fail %0t: outputs not at their reset values", $time);
      end
      reset_n = 1'b1;
      for (int i = 0; i < 13; i++) begin
         reg_access(reg_steps[i]);
      end
      for (int i = 0; i < 3; i++) begin
         if (!timed_out) begin
            @(negedge vga_clk);
            vga_mode_in = modes[i].mode;
            pix_check   = 1'b0;
            wait_frames(2);
            cur       = i;
            pix_check = 1'b1;
            wait_frames(1);
            pix_check = 1'b0;
            assert (line_len == modes[i].h_total && hs_width == modes[i].hs_width &&
                    frame_lines == modes[i].v_total) else begin
               errors++;
               $display("Fail %0t: mode %0d timing h=%0d hs=%0d v=%0d", $time, i,
                        line_len, hs_width, frame_lines);
            end
         end
      end
      $display("checked %0d pixels, %0d errors, timeout %0d", pix_checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== chroni_checker.sv ====
module chroni_checker import chroni_pkg::*; (
   input logic         vga_clk,
   input logic         reset_n,
   input logic         rd_req,
   input logic         rd_ack,
   input logic         wr_en,
   input logic [12:0]  addr_out,
   input fetch_state_e state,
   input beam_t        beam
);

   timeunit 1ns;
   timeprecision 1ps;

   // line_start may abandon a read that is still waiting
   assert property (@(posedge vga_clk) disable iff (!reset_n)
      rd_req && !rd_ack && !beam.line_start |=> rd_req)
      else $error("rd_req dropped before rd_ack");

   assert property (@(posedge vga_clk) disable iff (!reset_n)
      rd_req && !rd_ack && !beam.line_start |=> $stable(addr_out))
      else $error("addr_out changed while waiting for rd_ack");

   // a glyph is stored right after its acknowledged font read and within the render line
   assert property (@(posedge vga_clk) disable iff (!reset_n)
      wr_en |-> $past(state == fs_font_wait && rd_ack) && beam.render_line)
      else $error("line buffer write without a completed font read in a render line");

endmodule

bind chroni_text_fetch chroni_checker checker0 (
   .vga_clk  (vga_clk),
   .reset_n  (reset_n),
   .rd_req   (rd_req),
   .rd_ack   (rd_ack),
   .wr_en    (wr_en),
   .addr_out (addr_out),
   .state    (state),
   .beam     (beam)
);

// ==== chroni.sv ====
module chroni import chroni_pkg::*; (
   input  logic        vga_clk,
   input  logic        reset_n,
   input  vga_mode_e   vga_mode_in,
   output logic        vga_hs,
   output logic        vga_vs,
   output logic [4:0]  vga_r,
   output logic [5:0]  vga_g,
   output logic [4:0]  vga_b,
   input  logic [6:0]  cpu_addr,
   input  logic [7:0]  cpu_data_in,
   output logic [7:0]  cpu_data_out,
   input  logic        cpu_we,
   input  logic        cpu_re,
   output logic [12:0] addr_out,
   output logic [7:0]  addr_out_page,
   input  logic [7:0]  data_in,
   output logic        rd_req,
   input  logic        rd_ack
);

   regs_t        regs;
   beam_t        beam;
   mode_timing_t timing;
   logic         wr_en;
   logic [10:0]  wr_addr;
   logic [7:0]   wr_byte;
   logic         pixel;

   // input side
   chroni_regs regs0 (
      .vga_clk      (vga_clk),
      .reset_n      (reset_n),
      .cpu_addr     (cpu_addr),
      .cpu_data_in  (cpu_data_in),
      .cpu_we       (cpu_we),
      .cpu_re       (cpu_re),
      .cpu_data_out (cpu_data_out),
      .regs         (regs)
   );

   chroni_timing timing0 (
      .vga_clk     (vga_clk),
      .reset_n     (reset_n),
      .vga_mode_in (vga_mode_in),
      .beam        (beam),
      .timing      (timing)
   );

   // text fetch into the line buffer
   chroni_text_fetch fetch0 (
      .vga_clk       (vga_clk),
      .reset_n       (reset_n),
      .beam          (beam),
      .timing        (timing),
      .regs          (regs),
      .addr_out      (addr_out),
      .addr_out_page (addr_out_page),
      .data_in       (data_in),
      .rd_req        (rd_req),
      .rd_ack        (rd_ack),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_byte       (wr_byte)
   );

   chroni_line_buffer line_buf0 (
      .vga_clk (vga_clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_byte (wr_byte),
      .beam    (beam),
      .pixel   (pixel)
   );

   chroni_video_out video_out0 (
      .vga_clk (vga_clk),
      .reset_n (reset_n),
      .beam    (beam),
      .regs    (regs),
      .pixel   (pixel),
      .vga_hs  (vga_hs),
      .vga_vs  (vga_vs),
      .vga_r   (vga_r),
      .vga_g   (vga_g),
      .vga_b   (vga_b)
   );

endmodule

// ==== chroni_video_out.sv ====
module chroni_video_out import chroni_pkg::*; (
   input  logic       vga_clk,
   input  logic       reset_n,
   input  beam_t      beam,
   input  regs_t      regs,
   input  logic       pixel,
   output logic       vga_hs,
   output logic       vga_vs,
   output logic [4:0] vga_r,
   output logic [5:0] vga_g,
   output logic [4:0] vga_b
);

   rgb_t color;

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         vga_hs <= 1'b1;
         vga_vs <= 1'b1;
         color  <= '0;
      end else begin
         vga_hs <= beam.hs;
         vga_vs <= beam.vs;
         if (beam.pf) begin
            color <= pixel ? regs.fg : regs.bg;
         end else if (beam.de) begin
            color <= regs.border;
         end else begin
            // blanking
            color <= '0;
         end
      end
   end

   assign vga_r = color.r;
   assign vga_g = color.g;
   assign vga_b = color.b;

endmodule

// ==== chroni_line_buffer.sv ====
module chroni_line_buffer import chroni_pkg::*; (
   input  logic        vga_clk,
   input  logic        wr_en,
   input  logic [10:0] wr_addr,
   input  logic [7:0]  wr_byte,
   input  beam_t       beam,
   output logic        pixel
);

   logic        cells [line_buf_depth];
   logic [10:0] rd_addr;

   // msb of the glyph byte is the leftmost pixel, so it takes the lowest address
   always_ff @(posedge vga_clk) begin
      if (wr_en) begin
         for (int i = 0; i < 8; i++) begin
            cells[wr_addr + 11'(i)] <= wr_byte[7 - i];
         end
      end
   end

   assign rd_addr = (beam.read_row ? 11'(line_buf_row) : 11'd0) + beam.pixel_x;
   assign pixel   = cells[rd_addr];

endmodule

// ==== chroni_text_fetch.sv ====
module chroni_text_fetch import chroni_pkg::*; (
   input  logic         vga_clk,
   input  logic         reset_n,
   input  beam_t        beam,
   input  mode_timing_t timing,
   input  regs_t        regs,
   output logic [12:0]  addr_out,
   output logic [7:0]   addr_out_page,
   input  logic [7:0]   data_in,
   output logic         rd_req,
   input  logic         rd_ack,
   output logic         wr_en,
   output logic [10:0]  wr_addr,
   output logic [7:0]   wr_byte
);

   fetch_state_e state;
   logic [6:0]   col;
   logic [12:0]  char_addr;
   logic [12:0]  row_off;
   logic [10:0]  row_base;
   logic [7:0]   char_code;

   assign row_off = 13'(beam.text_row) * 13'(timing.text_cols);
   assign wr_en   = state == fs_store;
   assign wr_addr = row_base + {1'b0, col, 3'b000};

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         state  <= fs_idle;
         rd_req <= 1'b0;
         col    <= 7'd0;
      end else if (beam.line_start) begin
         // a fetch still running from the last line is dropped here
         state     <= fs_text_read;
         rd_req    <= 1'b0;
         col       <= 7'd0;
         char_addr <= regs.text_base + row_off;
         row_base  <= beam.write_row ? 11'(line_buf_row) : 11'd0;
      end else begin
         case (state)
            fs_idle: begin
               rd_req <= 1'b0;
            end
            fs_text_read: begin
               addr_out      <= char_addr;
               addr_out_page <= regs.page;
               rd_req        <= 1'b1;
               state         <= fs_text_wait;
            end
            fs_text_wait: begin
               if (rd_ack) begin
                  char_code <= data_in;
                  rd_req    <= 1'b0;
                  state     <= fs_font_read;
               end
            end
            fs_font_read: begin
               addr_out <= regs.font_base + {2'b00, char_code, beam.font_scan};
               rd_req   <= 1'b1;
               state    <= fs_font_wait;
            end
            fs_font_wait: begin
               if (rd_ack) begin
                  wr_byte <= data_in;
                  rd_req  <= 1'b0;
                  state   <= fs_store;
               end
            end
            fs_store: begin
               col       <= col + 7'd1;
               char_addr <= char_addr + 13'd1;
               if (col == timing.text_cols - 7'd1) begin
                  state <= fs_idle;
               end else begin
                  // next character read goes out while this glyph is stored
                  addr_out <= char_addr + 13'd1;
                  rd_req   <= 1'b1;
                  state    <= fs_text_wait;
               end
            end
            default: begin
               state <= fs_idle;
            end
         endcase
      end
   end

endmodule

// ==== chroni_timing.sv ====
module chroni_timing import chroni_pkg::*; (
   input  logic         vga_clk,
   input  logic         reset_n,
   input  vga_mode_e    vga_mode_in,
   output beam_t        beam,
   output mode_timing_t timing
);

   logic [11:0] x_cnt;
   logic [11:0] y_cnt;
   logic        line_end;
   logic        hs;
   logic        vs;
   logic        h_de;
   logic        v_de;
   logic        h_pf;
   logic        v_pf;
   logic        v_render;
   logic [9:0]  line_cnt;
   logic [9:0]  scan;
   logic        render_line;
   logic        buf_row;
   logic        line_start;
   logic        half;
   logic [10:0] pix_cnt;

   assign line_end = x_cnt == timing.h_total;

   // new mode only at the first pixel of a frame
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         timing <= mode_table[mode_640x480];
      end else if (x_cnt == 12'd1 && y_cnt == 12'd1) begin
         timing <= mode_table[vga_mode_in];
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         x_cnt <= 12'd1;
         y_cnt <= 12'd1;
      end else if (line_end) begin
         x_cnt <= 12'd1;
         y_cnt <= (y_cnt == timing.v_total) ? 12'd1 : y_cnt + 12'd1;
      end else begin
         x_cnt <= x_cnt + 12'd1;
      end
   end

   // horizontal flags, registered so that they line up with x_cnt
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         hs         <= 1'b1;
         h_de       <= 1'b0;
         h_pf       <= 1'b0;
         line_start <= 1'b0;
      end else begin
         if (line_end) begin
            hs <= 1'b0;
         end else if (x_cnt == timing.h_sync_pulse) begin
            hs <= 1'b1;
         end
         if (x_cnt == timing.h_de_start) begin
            h_de <= 1'b1;
         end else if (x_cnt == timing.h_de_end) begin
            h_de <= 1'b0;
         end
         if (x_cnt == timing.h_pf_start) begin
            h_pf <= 1'b1;
         end else if (x_cnt == timing.h_pf_end) begin
            h_pf <= 1'b0;
         end
         line_start <= (x_cnt == timing.h_pf_start) && render_line;
      end
   end

   // vertical flags change at the end of each line, for the line that follows
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         vs       <= 1'b1;
         v_de     <= 1'b0;
         v_pf     <= 1'b0;
         v_render <= 1'b0;
         line_cnt <= 10'd0;
         buf_row  <= 1'b0;
      end else if (line_end) begin
         if (y_cnt == timing.v_total) begin
            vs <= 1'b0;
         end else if (y_cnt == timing.v_sync_pulse) begin
            vs <= 1'b1;
         end
         if (y_cnt == timing.v_de_start) begin
            v_de <= 1'b1;
         end else if (y_cnt == timing.v_de_end) begin
            v_de <= 1'b0;
         end
         if (y_cnt == timing.v_pf_start) begin
            v_pf <= 1'b1;
         end else if (y_cnt == timing.v_pf_end) begin
            v_pf <= 1'b0;
         end
         // line_cnt is the playfield line that follows the current one
         if (y_cnt == timing.v_pf_start - 12'd1) begin
            v_render <= 1'b1;
            line_cnt <= 10'd0;
         end else begin
            if (y_cnt == timing.v_pf_end - 12'd1) begin
               v_render <= 1'b0;
            end
            line_cnt <= line_cnt + 10'd1;
         end
         if (render_line) begin
            buf_row <= ~buf_row;
         end
      end
   end

   always_ff @(posedge vga_clk) begin
      if (x_cnt == timing.h_pf_start) begin
         pix_cnt <= 11'd0;
         half    <= 1'b0;
      end else if (h_pf && x_cnt != timing.h_pf_end) begin
         half <= timing.dbl ? ~half : 1'b0;
         if (!timing.dbl || half) begin
            pix_cnt <= pix_cnt + 11'd1;
         end
      end
   end

   assign scan        = timing.dbl ? {1'b0, line_cnt[9:1]} : line_cnt;
   assign render_line = v_render && (!timing.dbl || !line_cnt[0]);

   always_comb begin
      beam.hs          = hs;
      beam.vs          = vs;
      beam.de          = h_de && v_de;
      beam.pf          = h_pf && v_pf;
      beam.pixel_x     = pix_cnt;
      beam.read_row    = ~buf_row;
      beam.render_line = render_line;
      beam.write_row   = buf_row;
      beam.text_row    = scan[9:3];
      beam.font_scan   = scan[2:0];
      beam.line_start  = line_start;
   end

endmodule

// ==== chroni_regs.sv ====
module chroni_regs import chroni_pkg::*; (
   input  logic        vga_clk,
   input  logic        reset_n,
   input  logic [6:0]  cpu_addr,
   input  logic [7:0]  cpu_data_in,
   input  logic        cpu_we,
   input  logic        cpu_re,
   output logic [7:0]  cpu_data_out,
   output regs_t       regs
);

   logic [7:0] rd_byte;

   always_comb begin
      case (cpu_addr)
         reg_border_lo: rd_byte = regs.border[7:0];
         reg_border_hi: rd_byte = regs.border[15:8];
         reg_fg_lo:     rd_byte = regs.fg[7:0];
         reg_fg_hi:     rd_byte = regs.fg[15:8];
         reg_bg_lo:     rd_byte = regs.bg[7:0];
         reg_bg_hi:     rd_byte = regs.bg[15:8];
         reg_text_lo:   rd_byte = regs.text_base[7:0];
         reg_text_hi:   rd_byte = {3'b000, regs.text_base[12:8]};
         reg_font_lo:   rd_byte = regs.font_base[7:0];
         reg_font_hi:   rd_byte = {3'b000, regs.font_base[12:8]};
         reg_page:      rd_byte = regs.page;
         default:       rd_byte = 8'd0;
      endcase
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         regs         <= '0;
         cpu_data_out <= 8'd0;
      end else begin
         if (cpu_we) begin
            case (cpu_addr)
               reg_border_lo: regs.border[7:0]     <= cpu_data_in;
               reg_border_hi: regs.border[15:8]    <= cpu_data_in;
               reg_fg_lo:     regs.fg[7:0]         <= cpu_data_in;
               reg_fg_hi:     regs.fg[15:8]        <= cpu_data_in;
               reg_bg_lo:     regs.bg[7:0]         <= cpu_data_in;
               reg_bg_hi:     regs.bg[15:8]        <= cpu_data_in;
               reg_text_lo:   regs.text_base[7:0]  <= cpu_data_in;
               reg_text_hi:   regs.text_base[12:8] <= cpu_data_in[4:0];
               reg_font_lo:   regs.font_base[7:0]  <= cpu_data_in;
               reg_font_hi:   regs.font_base[12:8] <= cpu_data_in[4:0];
               reg_page:      regs.page            <= cpu_data_in;
               default: ;
            endcase
         end
         if (cpu_re) begin
            cpu_data_out <= rd_byte;
         end
      end
   end

endmodule

// ==== chroni_pkg.sv ====
package chroni_pkg;

   typedef enum logic [1:0] {
      mode_640x480  = 2'd0,
      mode_800x600  = 2'd1,
      mode_1280x720 = 2'd2
   } vga_mode_e;

   // flags are set on the cycle after the *_start compare and cleared after *_end
   typedef struct packed {
      logic [11:0] h_sync_pulse;
      logic [11:0] h_total;
      logic [11:0] h_de_start;
      logic [11:0] h_de_end;
      logic [11:0] h_pf_start;
      logic [11:0] h_pf_end;
      logic [11:0] v_sync_pulse;
      logic [11:0] v_total;
      logic [11:0] v_de_start;
      logic [11:0] v_de_end;
      logic [11:0] v_pf_start;
      logic [11:0] v_pf_end;
      logic [6:0]  text_cols;
      logic        dbl;
   } mode_timing_t;

   localparam mode_timing_t mode_table [3] = '{
      '{h_sync_pulse: 12'd96, h_total: 12'd800, h_de_start: 12'd144, h_de_end: 12'd784,
        h_pf_start: 12'd144, h_pf_end: 12'd784, v_sync_pulse: 12'd2, v_total: 12'd525,
        v_de_start: 12'd35, v_de_end: 12'd515, v_pf_start: 12'd35, v_pf_end: 12'd515,
        text_cols: 7'd40, dbl: 1'b1},
      '{h_sync_pulse: 12'd128, h_total: 12'd1056, h_de_start: 12'd216, h_de_end: 12'd1016,
        h_pf_start: 12'd296, h_pf_end: 12'd936, v_sync_pulse: 12'd4, v_total: 12'd628,
        v_de_start: 12'd27, v_de_end: 12'd627, v_pf_start: 12'd87, v_pf_end: 12'd567,
        text_cols: 7'd40, dbl: 1'b1},
      '{h_sync_pulse: 12'd40, h_total: 12'd1650, h_de_start: 12'd260, h_de_end: 12'd1540,
        h_pf_start: 12'd420, h_pf_end: 12'd1380, v_sync_pulse: 12'd5, v_total: 12'd750,
        v_de_start: 12'd25, v_de_end: 12'd745, v_pf_start: 12'd25, v_pf_end: 12'd745,
        text_cols: 7'd120, dbl: 1'b0}
   };

   typedef struct packed {
      logic        hs;
      logic        vs;
      logic        de;
      logic        pf;
      logic [10:0] pixel_x;
      logic        read_row;
      logic        render_line;
      logic        write_row;
      logic [6:0]  text_row;
      logic [2:0]  font_scan;
      logic        line_start;
   } beam_t;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb_t;

   typedef struct packed {
      rgb_t        border;
      rgb_t        fg;
      rgb_t        bg;
      logic [12:0] text_base;
      logic [12:0] font_base;
      logic [7:0]  page;
   } regs_t;

   typedef enum logic [2:0] {
      fs_idle,
      fs_text_read,
      fs_text_wait,
      fs_font_read,
      fs_font_wait,
      fs_store
   } fetch_state_e;

   localparam logic [6:0] reg_border_lo = 7'd0;
   localparam logic [6:0] reg_border_hi = 7'd1;
   localparam logic [6:0] reg_fg_lo     = 7'd2;
   localparam logic [6:0] reg_fg_hi     = 7'd3;
   localparam logic [6:0] reg_bg_lo     = 7'd4;
   localparam logic [6:0] reg_bg_hi     = 7'd5;
   localparam logic [6:0] reg_text_lo   = 7'd6;
   localparam logic [6:0] reg_text_hi   = 7'd7;
   localparam logic [6:0] reg_font_lo   = 7'd8;
   localparam logic [6:0] reg_font_hi   = 7'd9;
   localparam logic [6:0] reg_page      = 7'd10;

   localparam int line_buf_row   = 960;
   localparam int line_buf_depth = 2 * line_buf_row;

endpackage
